/* build.f */
+incdir+design
design/lc4_pkg.sv
design/lc4_decoder.sv
design/lc4_regfile.sv
design/lc4_fetch.sv
design/lc4_decode.sv
design/lc4_execute.sv
design/lc4_mem_wb.sv
design/lc4_pipeline.sv
verification/lc4_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= lc4_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/lc4_tb.sv */
// Random LC4 program from seed 50 with a directed prologue; data memory is a 256-word model here
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_tb;
  import lc4_pkg::*;

  localparam int    PROG_N  = 200;
  localparam int    TIMEOUT = PROG_N * 3 + 40;  // Three cycles per insn covers stalls and flushes
  localparam word_t BASE    = `LC4_RESET_PC;
  localparam int    T_RESET = 0;
  localparam int    T_STREAM = 1;
  localparam int    T_LOAD = 2;
  localparam int    T_BRANCH = 3;
  localparam int    T_DONE = 4;

  logic       gwe;
  logic       i_rst_n;
  word_t      imem_addr;
  word_t      imem_insn;
  word_t      imem_off;
  word_t      dmem_addr;
  logic       dmem_we;
  word_t      dmem_wdata;
  word_t      dmem_rdata;
  trace_t     trace;
  logic       pend_we;     // Store seen at the falling edge, written after the next rise
  logic [7:0] pend_addr;
  word_t      pend_data;
  logic       bus_we;      // Data bus of the memory stage one cycle before the current entry
  word_t      bus_addr;
  word_t      bus_wdata;

  word_t      prog [PROG_N];
  word_t      dmem [256];
  word_t      m_regs [8];  // ISA model state
  word_t      m_dmem [256];
  logic [2:0] m_nzp;       // n z p
  word_t      m_pc;

  string      names [5];
  int         errs [5];
  logic       finished [5];
  int         passed, failed, checks, cycles, retired, load_since, flush_since;
  word_t      prev_pc;
  logic       done;

  lc4_pipeline UUT (
    .gwe (gwe), .i_rst_n (i_rst_n), .o_imem_addr (imem_addr), .i_imem_insn (imem_insn),
    .o_dmem_addr (dmem_addr), .o_dmem_we (dmem_we), .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata), .o_trace (trace)
  );

  assign imem_off   = imem_addr - BASE;
  assign imem_insn  = (imem_off < 16'(PROG_N)) ? prog[imem_off[7:0]] : 16'h0000;  // NOP past end
  assign dmem_rdata = dmem[dmem_addr[7:0]];   // Low 8 bits index the data memory

  initial begin
    gwe = 1'b0;
    forever #2 gwe = ~gwe;
  end

  always @(negedge gwe) begin
    pend_we   = dmem_we;
    pend_addr = dmem_addr[7:0];
    pend_data = dmem_wdata;
  end

  always @(posedge gwe) begin
    #1;
    if (pend_we)
      dmem[pend_addr] = pend_data;
  end

  function automatic word_t fill_word(input int i);
    return {8'(i), ~8'(i)} ^ 16'h3c5a;   // Every address bit shows up in the word
  endfunction

  // One instruction of the kept subset
  function automatic word_t rand_insn();
    logic [2:0]  rd, rs, rt, nzp;
    logic [8:0]  imm9;
    int unsigned kind;
    rd   = 3'($urandom);
    rs   = 3'($urandom);
    rt   = 3'($urandom);
    imm9 = 9'($urandom);
    nzp  = 3'(1 + $urandom % 7);         // Never the NOP form
    kind = $urandom % 11;
    case (kind)
      0:  return {`LC4_OP_ARITH, rd, rs, `LC4_SUB_ADD, rt};
      1:  return {`LC4_OP_ARITH, rd, rs, `LC4_SUB_SUB, rt};
      2:  return {`LC4_OP_ARITH, rd, rs, 1'b1, imm9[4:0]};
      3:  return {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_AND, rt};
      4:  return {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_OR, rt};
      5:  return {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_XOR, rt};
      6:  return {`LC4_OP_LOGIC, rd, rs, 1'b1, imm9[4:0]};
      7:  return {`LC4_OP_CONST, rd, imm9};
      8:  return {`LC4_OP_LDR, rd, rs, imm9[5:0]};
      9:  return {`LC4_OP_STR, rt, rs, imm9[5:0]};
      default: return {`LC4_OP_BR, nzp, 9'(1 + $urandom % 8)};   // Forward 1 to 8
    endcase
  endfunction

  task automatic check_eq(input int id, input string what, input word_t want, input word_t got);
    checks++;
    assert (got === want) else begin
      $display("mismatch %s %s: expected %h, actual %h", names[id], what, want, got);
      errs[id]++;
    end
  endtask

  task automatic finish_test(input int id);
    finished[id] = 1'b1;
    if (errs[id] == 0) begin
      passed++;
      $display("test %-13s done, no errors", names[id]);
    end else begin
      failed++;
      $display("test %-13s done, %0d errors", names[id], errs[id]);
    end
  endtask

  task automatic check_reset();
    check_eq(T_RESET, "stall", 16'(STALL_FLUSH), 16'(trace.stall));
    check_eq(T_RESET, "regfile_we", 16'd0, 16'(trace.regfile_we));
    check_eq(T_RESET, "nzp_we", 16'd0, 16'(trace.nzp_we));
    check_eq(T_RESET, "dmem_we", 16'd0, 16'(trace.dmem_we));
    check_eq(T_RESET, "imem_addr", BASE, imem_addr);
  endtask

  // Executes the next instruction in program order and gives its expected trace
  task automatic model_step(output trace_t want);
    word_t insn, off, a, b, res, addr, next;
    logic  wr;
    off  = m_pc - BASE;
    insn = (off < 16'(PROG_N)) ? prog[off[7:0]] : 16'h0000;
    a    = m_regs[insn[8:6]];
    b    = m_regs[insn[2:0]];
    addr = a + {{10{insn[5]}}, insn[5:0]};        // LDR and STR address
    res  = 16'd0;
    wr   = 1'b1;
    next = m_pc + 16'd1;
    want = '0;
    want.stall = STALL_NONE;
    want.pc    = m_pc;
    want.insn  = insn;
    case (insn[15:12])
      `LC4_OP_ARITH: begin
        if (insn[5]) res = a + {{11{insn[4]}}, insn[4:0]};
        else if (insn[5:3] == 3'b000) res = a + b;
        else if (insn[5:3] == 3'b010) res = a - b;
        else wr = 1'b0;                           // MUL and DIV are not kept
      end
      `LC4_OP_LOGIC: begin
        if (insn[5]) res = a & {{11{insn[4]}}, insn[4:0]};
        else if (insn[5:3] == 3'b000) res = a & b;
        else if (insn[5:3] == 3'b010) res = a | b;
        else if (insn[5:3] == 3'b011) res = a ^ b;
        else wr = 1'b0;
      end
      `LC4_OP_CONST: res = {{7{insn[8]}}, insn[8:0]};
      `LC4_OP_LDR: begin
        res = m_dmem[addr[7:0]];
        want.dmem_addr = addr;
        want.dmem_data = res;
      end
      `LC4_OP_STR: begin
        wr = 1'b0;
        want.dmem_we   = 1'b1;
        want.dmem_addr = addr;
        want.dmem_data = m_regs[insn[11:9]];
        m_dmem[addr[7:0]] = m_regs[insn[11:9]];
      end
      `LC4_OP_BR: begin
        wr = 1'b0;
        if (|(insn[11:9] & m_nzp))
          next = m_pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
      end
      default: wr = 1'b0;
    endcase
    if (wr) begin
      m_nzp = {res[15], res == 16'd0, !res[15] && res != 16'd0};
      m_regs[insn[11:9]] = res;
      want.regfile_we   = 1'b1;
      want.regfile_wsel = insn[11:9];
      want.regfile_data = res;
      want.nzp_we       = 1'b1;
      want.nzp_bits     = m_nzp;
    end
    m_pc = next;
  endtask

  task automatic check_retire(input trace_t t);
    trace_t want;
    model_step(want);
    check_eq(T_STREAM, "pc", want.pc, t.pc);
    check_eq(T_STREAM, "insn", want.insn, t.insn);
    check_eq(T_STREAM, "regfile_we", 16'(want.regfile_we), 16'(t.regfile_we));
    if (want.regfile_we) begin                    // Select and data only mean something on a write
      check_eq(T_STREAM, "regfile_wsel", 16'(want.regfile_wsel), 16'(t.regfile_wsel));
      check_eq(T_STREAM, "regfile_data", want.regfile_data, t.regfile_data);
    end
    check_eq(T_STREAM, "nzp_we", 16'(want.nzp_we), 16'(t.nzp_we));
    if (want.nzp_we)
      check_eq(T_STREAM, "nzp_bits", {13'd0, want.nzp_bits}, {13'd0, t.nzp_bits});
    check_eq(T_STREAM, "dmem_we", 16'(want.dmem_we), 16'(t.dmem_we));
    check_eq(T_STREAM, "dmem_addr", want.dmem_addr, t.dmem_addr);
    check_eq(T_STREAM, "dmem_data", want.dmem_data, t.dmem_data);
    // Same instruction as seen on the data memory port a cycle earlier
    check_eq(T_STREAM, "bus dmem_we", 16'(want.dmem_we), 16'(bus_we));
    check_eq(T_STREAM, "bus dmem_addr", want.dmem_addr, bus_addr);
    if (want.dmem_we)
      check_eq(T_STREAM, "bus dmem_wdata", want.dmem_data, bus_wdata);
  endtask

  task automatic process_entry(input trace_t t);
    if (t.stall == STALL_LOAD) begin
      load_since++;
    end else if (t.stall == STALL_FLUSH) begin
      flush_since++;
    end else begin
      if (prev_pc == BASE + 16'd3) begin         // LDR R3 just retired so the dependent ADD is next
        check_eq(T_LOAD, "stall count", 16'd1, 16'(load_since));
        check_eq(T_LOAD, "pc", BASE + 16'd4, t.pc);
        check_eq(T_LOAD, "data", 16'h0055, t.regfile_data);
        finish_test(T_LOAD);
      end
      if (prev_pc == BASE + 16'd5) begin         // Taken BRp
        check_eq(T_BRANCH, "taken flush count", 16'd2, 16'(flush_since));
        check_eq(T_BRANCH, "target pc", BASE + 16'd8, t.pc);
      end
      if (prev_pc == BASE + 16'd8) begin         // Not-taken BRn
        check_eq(T_BRANCH, "not-taken flush count", 16'd0, 16'(flush_since));
        check_eq(T_BRANCH, "fall-through pc", BASE + 16'd9, t.pc);
        finish_test(T_BRANCH);
      end
      check_retire(t);
      retired++;
      prev_pc     = t.pc;
      load_since  = 0;
      flush_since = 0;
      if (m_pc - BASE >= 16'(PROG_N))
        done = 1'b1;                              // Model ran past the last program word
    end
  endtask

  initial begin
    void'($urandom(50));
    i_rst_n   = 1'b0;
    pend_we   = 1'b0;
    pend_addr = 8'd0;
    pend_data = 16'd0;
    bus_we    = 1'b0;
    bus_addr  = 16'd0;
    bus_wdata = 16'd0;
    names     = '{"reset", "random_stream", "load_use", "branch_flush", "completion"};
    for (int i = 0; i < 5; i++) begin
      errs[i]     = 0;
      finished[i] = 1'b0;
    end
    {passed, failed, checks, cycles, retired, load_since, flush_since} = '0;
    prev_pc = 16'd0;
    done    = 1'b0;
    for (int i = 0; i < 256; i++) begin
      dmem[i]   = fill_word(i);
      m_dmem[i] = fill_word(i);
    end
    for (int i = 0; i < 8; i++)
      m_regs[i] = 16'd0;
    m_nzp = 3'b010;                               // Z after reset
    m_pc  = BASE;
    // Directed prologue, then random code
    prog[0] = {`LC4_OP_CONST, 3'd1, 9'h010};            // R1 = 0x10
    prog[1] = {`LC4_OP_CONST, 3'd2, 9'h055};            // R2 = 0x55
    prog[2] = {`LC4_OP_STR, 3'd2, 3'd1, 6'd0};          // mem[0x10] = R2
    prog[3] = {`LC4_OP_LDR, 3'd3, 3'd1, 6'd0};          // R3 = mem[0x10]
    prog[4] = {`LC4_OP_ARITH, 3'd4, 3'd3, 1'b1, 5'd0};  // R4 = R3 + 0 needs R3 at once
    prog[5] = {`LC4_OP_BR, 3'b001, 9'd2};               // BRp, taken to prog[8]
    prog[6] = {`LC4_OP_CONST, 3'd5, 9'h001};            // Skipped
    prog[7] = {`LC4_OP_CONST, 3'd6, 9'h002};            // Skipped
    prog[8] = {`LC4_OP_BR, 3'b100, 9'd1};               // BRn, falls through
    for (int i = 9; i < PROG_N; i++)
      prog[i] = rand_insn();

    @(negedge gwe);
    check_reset();                                // Still in reset
    @(posedge gwe);
    #1 i_rst_n = 1'b1;                            // Two rising edges seen in reset

    while (!done && cycles < TIMEOUT) begin
      @(negedge gwe);
      cycles++;
      if (cycles == 1) begin
        check_reset();
        finish_test(T_RESET);
      end
      process_entry(trace);
      bus_we    = dmem_we;                        // This instruction retires on the next entry
      bus_addr  = dmem_addr;
      bus_wdata = dmem_wdata;
    end

    assert (done) else begin
      $display("completion: the pipeline stopped retiring, timeout after %0d cycles", cycles);
      errs[T_DONE]++;
    end
    assert (finished[T_LOAD]) else begin
      $display("load_use: the directed load and its dependent ADD never retired");
      errs[T_LOAD]++;
      finish_test(T_LOAD);
    end
    assert (finished[T_BRANCH]) else begin
      $display("branch_flush: the directed branches never retired");
      errs[T_BRANCH]++;
      finish_test(T_BRANCH);
    end
    finish_test(T_STREAM);
    finish_test(T_DONE);
    $display("tests passed %0d, failed %0d, checks %0d, retired %0d, cycles %0d",
             passed, failed, checks, retired, cycles);
    if (failed == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* design/lc4_pipeline.sv */
// Five-stage LC4 subset core; both memories are external and read combinationally
`timescale 1ns/1ps

module lc4_pipeline (
  input  logic            gwe,
  input  logic            i_rst_n,
  output lc4_pkg::word_t  o_imem_addr,
  input  lc4_pkg::word_t  i_imem_insn,
  output lc4_pkg::word_t  o_dmem_addr,
  output logic            o_dmem_we,
  output lc4_pkg::word_t  o_dmem_wdata,
  input  lc4_pkg::word_t  i_dmem_rdata,
  output lc4_pkg::trace_t o_trace
);
  import lc4_pkg::*;

  fd_t   fd;
  dx_t   dx;
  xm_t   xm;
  wb_t   m_fwd;      // From the memory stage
  wb_t   w_fwd;      // From writeback, also the regfile write
  nzp_t  nzp;
  logic  stall;      // Load-use
  logic  flush;      // Taken branch
  word_t target;

  lc4_fetch u_fetch (
    .gwe (gwe), .i_rst_n (i_rst_n), .i_stall (stall), .i_flush (flush),
    .i_target (target), .o_pc (o_imem_addr), .i_insn (i_imem_insn), .o_fd (fd)
  );

  lc4_decode u_decode (
    .gwe (gwe), .i_rst_n (i_rst_n), .i_fd (fd), .i_flush (flush),
    .i_wb (w_fwd), .o_stall (stall), .o_dx (dx)
  );

  lc4_execute u_execute (
    .gwe (gwe), .i_rst_n (i_rst_n), .i_dx (dx), .i_m_fwd (m_fwd), .i_w_fwd (w_fwd),
    .i_nzp (nzp), .o_flush (flush), .o_target (target), .o_xm (xm)
  );

  lc4_mem_wb u_mem_wb (
    .gwe (gwe), .i_rst_n (i_rst_n), .i_xm (xm), .o_dmem_addr (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata), .o_dmem_we (o_dmem_we), .i_dmem_rdata (i_dmem_rdata),
    .o_m_fwd (m_fwd), .o_w_fwd (w_fwd), .o_nzp (nzp), .o_trace (o_trace)
  );

endmodule

/* design/lc4_mem_wb.sv */
// Data memory must answer combinationally; address is forced to zero for non-memory ops
`timescale 1ns/1ps

module lc4_mem_wb (
  input  logic            gwe,
  input  logic            i_rst_n,
  input  lc4_pkg::xm_t    i_xm,
  output lc4_pkg::word_t  o_dmem_addr,
  output lc4_pkg::word_t  o_dmem_wdata,
  output logic            o_dmem_we,
  input  lc4_pkg::word_t  i_dmem_rdata,
  output lc4_pkg::wb_t    o_m_fwd,
  output lc4_pkg::wb_t    o_w_fwd,
  output lc4_pkg::nzp_t   o_nzp,
  output lc4_pkg::trace_t o_trace
);
  import lc4_pkg::*;

  logic  mem_op;
  word_t dmem_addr;
  word_t dmem_data;   // Word seen on the data bus
  word_t wdata;
  mw_t   mw;
  nzp_t  nzp_q;

  assign mem_op       = i_xm.ctrl.is_load || i_xm.ctrl.is_store;
  assign dmem_addr    = mem_op ? i_xm.result : '0;
  assign o_dmem_addr  = dmem_addr;
  assign o_dmem_we    = i_xm.ctrl.is_store;
  assign o_dmem_wdata = i_xm.store_data;

  assign wdata     = i_xm.ctrl.is_load ? i_dmem_rdata : i_xm.result;
  assign dmem_data = i_xm.ctrl.is_store ? i_xm.store_data :
                     i_xm.ctrl.is_load  ? i_dmem_rdata : '0;

  // Memory-stage record carries load data for forwarding
  assign o_m_fwd = '{we: i_xm.ctrl.regfile_we, sel: i_xm.ctrl.rd,
                     data: wdata, nzp_we: i_xm.ctrl.nzp_we};

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mw       <= '0;
      mw.stall <= STALL_FLUSH;
    end else begin
      mw <= '{pc: i_xm.pc, insn: i_xm.insn, ctrl: i_xm.ctrl, wdata: wdata,
              dmem_we: i_xm.ctrl.is_store, dmem_addr: dmem_addr,
              dmem_data: dmem_data, stall: i_xm.stall};
    end
  end

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n)
      nzp_q <= '{n: 1'b0, z: 1'b1, p: 1'b0};   // Z after reset
    else if (mw.ctrl.nzp_we)
      nzp_q <= nzp_of(mw.wdata);
  end

  // Writeback record also drives the register file write
  assign o_w_fwd = '{we: mw.ctrl.regfile_we, sel: mw.ctrl.rd,
                     data: mw.wdata, nzp_we: mw.ctrl.nzp_we};
  assign o_nzp   = nzp_q;

  assign o_trace = '{stall: mw.stall, pc: mw.pc, insn: mw.insn,
                     regfile_we: mw.ctrl.regfile_we, regfile_wsel: mw.ctrl.rd,
                     regfile_data: mw.wdata, nzp_we: mw.ctrl.nzp_we,
                     nzp_bits: nzp_of(mw.wdata), dmem_we: mw.dmem_we,
                     dmem_addr: mw.dmem_addr, dmem_data: mw.dmem_data};

endmodule

/* design/lc4_execute.sv */
// Branch resolves here in the same cycle; forwarding favors memory over writeback
`timescale 1ns/1ps

module lc4_execute (
  input  logic           gwe,
  input  logic           i_rst_n,
  input  lc4_pkg::dx_t   i_dx,
  input  lc4_pkg::wb_t   i_m_fwd,
  input  lc4_pkg::wb_t   i_w_fwd,
  input  lc4_pkg::nzp_t  i_nzp,
  output logic           o_flush,
  output lc4_pkg::word_t o_target,
  output lc4_pkg::xm_t   o_xm
);
  import lc4_pkg::*;

  word_t rs_val;      // Forwarded operands
  word_t rt_val;
  word_t op_b;
  word_t result;
  nzp_t  nzp_fwd;     // Condition bits as of this instruction

  // Youngest older writer wins
  function automatic word_t fwd_pick(input reg_sel_t sel, input word_t latched);
    if (i_m_fwd.we && i_m_fwd.sel == sel)
      return i_m_fwd.data;
    else if (i_w_fwd.we && i_w_fwd.sel == sel)
      return i_w_fwd.data;
    else
      return latched;
  endfunction

  always_comb begin
    rs_val = fwd_pick(i_dx.ctrl.rs, i_dx.rs_data);
    rt_val = fwd_pick(i_dx.ctrl.rt, i_dx.rt_data);
  end

  always_comb begin
    if (i_m_fwd.nzp_we)
      nzp_fwd = nzp_of(i_m_fwd.data);
    else if (i_w_fwd.nzp_we)
      nzp_fwd = nzp_of(i_w_fwd.data);  // Register updates at the next edge
    else
      nzp_fwd = i_nzp;
  end

  assign op_b = i_dx.ctrl.use_imm ? i_dx.ctrl.imm : rt_val;

  always_comb begin
    case (i_dx.ctrl.alu_op)
      ALU_ADD:    result = rs_val + op_b;
      ALU_SUB:    result = rs_val - op_b;
      ALU_AND:    result = rs_val & op_b;
      ALU_OR:     result = rs_val | op_b;
      ALU_XOR:    result = rs_val ^ op_b;
      ALU_PASS_B: result = op_b;                      // CONST
      ALU_ADDR:   result = rs_val + i_dx.ctrl.imm;    // Effective address
      default:    result = '0;
    endcase
  end

  // Taken when any requested condition bit is set
  assign o_flush  = i_dx.ctrl.is_branch && |(i_dx.insn[11:9] & nzp_fwd);
  assign o_target = i_dx.pc + word_t'(1) + i_dx.ctrl.imm;

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_xm       <= '0;
      o_xm.stall <= STALL_FLUSH;
    end else begin
      o_xm.pc         <= i_dx.pc;
      o_xm.insn       <= i_dx.insn;
      o_xm.ctrl       <= i_dx.ctrl;
      o_xm.result     <= result;
      o_xm.store_data <= rt_val;        // Store value after forwarding
      o_xm.stall      <= i_dx.stall;
    end
  end

endmodule

/* design/lc4_decode.sv */
// Stalls one cycle behind a load for any dependent read, including a branch reading NZP
`timescale 1ns/1ps

module lc4_decode (
  input  logic         gwe,
  input  logic         i_rst_n,
  input  lc4_pkg::fd_t i_fd,
  input  logic         i_flush,
  input  lc4_pkg::wb_t i_wb,
  output logic         o_stall,
  output lc4_pkg::dx_t o_dx
);
  import lc4_pkg::*;

  ctrl_t ctrl_raw;
  ctrl_t ctrl;        // Zeroed for bubbles so they never stall
  word_t rs_data;
  word_t rt_data;
  dx_t   dx_next;

  lc4_decoder u_decoder (
    .i_insn (i_fd.insn),
    .o_ctrl (ctrl_raw)
  );

  assign ctrl = (i_fd.stall == STALL_NONE) ? ctrl_raw : '0;

  // Reads use the decoded selects, the write comes from writeback
  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_rs      (ctrl.rs),
    .i_rt      (ctrl.rt),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data),
    .i_wb      (i_wb)
  );

  // Load data is too late for the next instruction's execute
  assign o_stall = o_dx.ctrl.is_load &&
                   ((ctrl.rs_re && ctrl.rs == o_dx.ctrl.rd) ||
                    (ctrl.rt_re && ctrl.rt == o_dx.ctrl.rd) ||
                    ctrl.is_branch);   // Load also writes NZP

  always_comb begin
    dx_next = '0;
    if (i_flush) begin
      dx_next.stall = STALL_FLUSH;     // Flush wins over stall
    end else if (o_stall) begin
      dx_next.stall = STALL_LOAD;      // One bubble while fd holds
    end else begin
      dx_next.pc      = i_fd.pc;
      dx_next.insn    = i_fd.insn;
      dx_next.ctrl    = ctrl;
      dx_next.rs_data = rs_data;
      dx_next.rt_data = rt_data;
      dx_next.stall   = i_fd.stall;    // Flush bubbles pass through
    end
  end

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dx       <= '0;
      o_dx.stall <= STALL_FLUSH;
    end else begin
      o_dx <= dx_next;
    end
  end

endmodule

/* design/lc4_fetch.sv */
// Predicts not-taken; flush from execute beats the load-use stall from decode
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_fetch (
  input  logic          gwe,
  input  logic          i_rst_n,
  input  logic          i_stall,
  input  logic          i_flush,
  input  lc4_pkg::word_t i_target,
  output lc4_pkg::word_t o_pc,
  input  lc4_pkg::word_t i_insn,
  output lc4_pkg::fd_t   o_fd
);
  import lc4_pkg::*;

  word_t pc;
  word_t pc_next;

  always_comb begin
    if (i_flush)
      pc_next = i_target;            // Redirect to resolved branch target
    else if (i_stall)
      pc_next = pc;                  // Refetch the same word
    else
      pc_next = pc + word_t'(1);
  end

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n)
      pc <= `LC4_RESET_PC;
    else
      pc <= pc_next;
  end

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_fd       <= '0;
      o_fd.stall <= STALL_FLUSH;     // Empty slot after reset
    end else if (i_flush) begin
      o_fd       <= '0;              // Wrong-path word is dropped
      o_fd.stall <= STALL_FLUSH;
    end else if (!i_stall) begin
      o_fd <= '{pc: pc, insn: i_insn, stall: STALL_NONE};
    end                              // Stall holds the latch
  end

  assign o_pc = pc;   // Instruction memory address

endmodule

/* design/lc4_regfile.sv */
// Two combinational reads, one write on the gwe edge; a same-cycle write bypasses to the reads
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_regfile (
  input  logic              gwe,
  input  logic              i_rst_n,
  input  lc4_pkg::reg_sel_t i_rs,
  input  lc4_pkg::reg_sel_t i_rt,
  output lc4_pkg::word_t    o_rs_data,
  output lc4_pkg::word_t    o_rt_data,
  input  lc4_pkg::wb_t      i_wb
);
  import lc4_pkg::*;

  word_t regs [`LC4_REG_N];   // R0..R7 with no hardwired zero in LC4

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `LC4_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.we) begin
      regs[i_wb.sel] <= i_wb.data;
    end
  end

  // Write-through so decode sees the writeback result this cycle
  assign o_rs_data = (i_wb.we && i_wb.sel == i_rs) ? i_wb.data : regs[i_rs];
  assign o_rt_data = (i_wb.we && i_wb.sel == i_rt) ? i_wb.data : regs[i_rt];

endmodule

/* design/lc4_decoder.sv */
// Pure combinational decode; MUL, DIV, NOT, shifts, compares and control transfers give a NOP
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_decoder (
  input  lc4_pkg::word_t i_insn,
  output lc4_pkg::ctrl_t o_ctrl
);
  import lc4_pkg::*;

  logic [3:0] opcode;
  logic [2:0] sub_op;
  logic       imm_form;   // insn[5] selects imm5 in ARITH and LOGIC
  word_t      imm5;
  word_t      imm6;
  word_t      imm9;

  assign opcode   = i_insn[15:12];
  assign sub_op   = i_insn[5:3];
  assign imm_form = i_insn[5];
  assign imm5     = {{(`LC4_WORD_W-5){i_insn[4]}}, i_insn[4:0]};
  assign imm6     = {{(`LC4_WORD_W-6){i_insn[5]}}, i_insn[5:0]};
  assign imm9     = {{(`LC4_WORD_W-9){i_insn[8]}}, i_insn[8:0]};

  always_comb begin
    logic rr;  // rd = rs op rt
    logic ri;  // rd = rs op imm5
    rr            = 1'b0;
    ri            = 1'b0;
    o_ctrl        = '0;             // All enables low unless matched below
    o_ctrl.rs     = i_insn[8:6];
    o_ctrl.rt     = i_insn[2:0];
    o_ctrl.rd     = i_insn[11:9];
    o_ctrl.alu_op = ALU_ADD;
    case (opcode)
      `LC4_OP_BR: begin
        o_ctrl.is_branch = |i_insn[11:9];   // nzp=000 is the NOP word
        o_ctrl.imm       = imm9;
      end
      `LC4_OP_ARITH: begin
        ri = imm_form;                        // ADD imm5
        rr = !imm_form && (sub_op == `LC4_SUB_ADD || sub_op == `LC4_SUB_SUB);
        if (!imm_form && sub_op == `LC4_SUB_SUB)
          o_ctrl.alu_op = ALU_SUB;
      end
      `LC4_OP_LOGIC: begin
        ri            = imm_form;             // AND imm5
        o_ctrl.alu_op = ALU_AND;
        if (!imm_form) begin
          case (sub_op)
            `LC4_SUB_AND: rr = 1'b1;
            `LC4_SUB_OR: begin
              rr            = 1'b1;
              o_ctrl.alu_op = ALU_OR;
            end
            `LC4_SUB_XOR: begin
              rr            = 1'b1;
              o_ctrl.alu_op = ALU_XOR;
            end
            default: rr = 1'b0;               // NOT stays a NOP
          endcase
        end
      end
      `LC4_OP_LDR: begin
        o_ctrl.rs_re      = 1'b1;
        o_ctrl.regfile_we = 1'b1;
        o_ctrl.nzp_we     = 1'b1;             // Loads set NZP too
        o_ctrl.is_load    = 1'b1;
        o_ctrl.alu_op     = ALU_ADDR;
        o_ctrl.use_imm    = 1'b1;
        o_ctrl.imm        = imm6;
      end
      `LC4_OP_STR: begin
        o_ctrl.rt       = i_insn[11:9];       // Store source lives in the rd slot
        o_ctrl.rs_re    = 1'b1;
        o_ctrl.rt_re    = 1'b1;
        o_ctrl.is_store = 1'b1;
        o_ctrl.alu_op   = ALU_ADDR;
        o_ctrl.use_imm  = 1'b1;
        o_ctrl.imm      = imm6;
      end
      `LC4_OP_CONST: begin
        o_ctrl.regfile_we = 1'b1;
        o_ctrl.nzp_we     = 1'b1;
        o_ctrl.alu_op     = ALU_PASS_B;
        o_ctrl.use_imm    = 1'b1;
        o_ctrl.imm        = imm9;
      end
      default: o_ctrl.alu_op = ALU_ADD;       // Unknown opcode
    endcase
    if (rr || ri) begin
      o_ctrl.rs_re      = 1'b1;
      o_ctrl.rt_re      = rr;
      o_ctrl.regfile_we = 1'b1;
      o_ctrl.nzp_we     = 1'b1;
      o_ctrl.use_imm    = ri;
      o_ctrl.imm        = ri ? imm5 : '0;
    end
  end

endmodule

/* design/lc4_pkg.sv */
// Shared pipeline types; stall codes match the LC4 test-pin encoding (1 unused)
`include "lc4_macros.svh"

package lc4_pkg;

  typedef logic [`LC4_WORD_W-1:0] word_t;     // Data, address or instruction
  typedef logic [2:0]             reg_sel_t;  // One of R0..R7

  // Same bit order as the nzp field of BR
  typedef struct packed {
    logic n;
    logic z;
    logic p;
  } nzp_t;

  typedef enum logic [1:0] {
    STALL_NONE  = 2'd0,  // Real instruction
    STALL_FLUSH = 2'd2,  // Killed by a taken branch or reset
    STALL_LOAD  = 2'd3   // Load-use bubble
  } stall_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B,  // CONST
    ALU_ADDR     // rs + imm6 for LDR and STR
  } alu_op_t;

  typedef struct packed {
    reg_sel_t rs;
    reg_sel_t rt;
    reg_sel_t rd;
    logic     rs_re;
    logic     rt_re;
    logic     regfile_we;
    logic     nzp_we;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    alu_op_t  alu_op;
    word_t    imm;       // Already sign extended
    logic     use_imm;   // ALU B operand comes from imm
  } ctrl_t;

  typedef struct packed {
    word_t  pc;
    word_t  insn;
    stall_t stall;
  } fd_t;

  typedef struct packed {
    word_t  pc;
    word_t  insn;
    ctrl_t  ctrl;
    word_t  rs_data;
    word_t  rt_data;
    stall_t stall;
  } dx_t;

  typedef struct packed {
    word_t  pc;
    word_t  insn;
    ctrl_t  ctrl;
    word_t  result;      // ALU result or memory address
    word_t  store_data;  // Forwarded rt
    stall_t stall;
  } xm_t;

  typedef struct packed {
    word_t  pc;
    word_t  insn;
    ctrl_t  ctrl;
    word_t  wdata;       // Load data or ALU result
    logic   dmem_we;
    word_t  dmem_addr;
    word_t  dmem_data;   // Word read or written
    stall_t stall;
  } mw_t;

  // Register and NZP write seen by forwarding and the register file
  typedef struct packed {
    logic     we;
    reg_sel_t sel;
    word_t    data;
    logic     nzp_we;
  } wb_t;

  typedef struct packed {
    stall_t   stall;
    word_t    pc;
    word_t    insn;
    logic     regfile_we;
    reg_sel_t regfile_wsel;
    word_t    regfile_data;
    logic     nzp_we;
    nzp_t     nzp_bits;
    logic     dmem_we;
    word_t    dmem_addr;
    word_t    dmem_data;
  } trace_t;

  // Condition bits of a result written to the register file
  function automatic nzp_t nzp_of(input word_t value);
    nzp_t bits;
    bits.n = value[`LC4_WORD_W-1];
    bits.z = (value == '0);
    bits.p = !bits.n && !bits.z;
    return bits;
  endfunction

endpackage

/* design/lc4_macros.svh */
// LC4 encodings for the kept subset only; any opcode not listed here decodes as a NOP
`ifndef LC4_MACROS_SVH
`define LC4_MACROS_SVH

`define LC4_WORD_W    16          // Data, address and instruction width
`define LC4_REG_N     8           // Register file depth
`define LC4_RESET_PC  16'h8200    // First fetch address after reset

// Opcode in insn[15:12]
`define LC4_OP_BR     4'b0000     // nzp in [11:9], imm9 in [8:0]
`define LC4_OP_ARITH  4'b0001
`define LC4_OP_LOGIC  4'b0101
`define LC4_OP_LDR    4'b0110     // rd, rs, imm6
`define LC4_OP_STR    4'b0111     // rt sits in [11:9]
`define LC4_OP_CONST  4'b1001     // rd, imm9

// Sub-op in insn[5:3] for register forms
// Setting insn[5] picks the imm5 form instead
`define LC4_SUB_ADD   3'b000
`define LC4_SUB_SUB   3'b010
`define LC4_SUB_AND   3'b000
`define LC4_SUB_OR    3'b010
`define LC4_SUB_XOR   3'b011

`endif
